// File: tb/tag_cases.txt
# P set tag wr hit way | A set tag need way addr (addr 0 = not checked) | all hex
# F set way | I | D has set way tag
D 0 00 0 000000
P 03 0abc00 0 0 0
A 03 0abc00 0 0 00000000
P 03 0abc00 0 1 0
P 03 0abc99 0 0 0
# fill the rest of set 3
A 03 0abc01 0 1 00000000
A 03 0abc02 0 2 00000000
A 03 0abc03 0 3 00000000
# reorder use, way 2 becomes oldest
P 03 0abc00 0 1 0
P 03 0abc01 0 1 1
A 03 0abc04 0 2 0abc0218
P 03 0abc02 0 0 0
P 03 0abc04 0 1 2
# write hits and the dirty scan
P 03 0abc03 1 1 3
D 1 03 3 0abc03
A 01 05a5a0 0 0 00000000
P 01 05a5a0 1 1 0
D 1 01 0 05a5a0
F 01 0
D 1 03 3 0abc03
# make the dirty way 3 oldest and evict it
P 03 0abc00 0 1 0
P 03 0abc01 0 1 1
P 03 0abc04 0 1 2
A 03 0abc05 1 3 0abc0318
D 0 00 0 000000
P 03 0abc00 1 1 0
D 1 03 0 0abc00
F 03 0
D 0 00 0 000000
# stale dirty bit across invalidate
P 03 0abc01 1 1 1
D 1 03 1 0abc01
I
D 0 00 0 000000
P 03 0abc01 0 0 0
P 01 05a5a0 0 0 0
A 03 0abc10 0 0 0abc0018
D 0 00 0 000000
A 03 0abc11 0 1 0abc0118
P 03 0abc10 0 1 0
P 03 0abc11 0 1 1
P 03 0abc05 0 0 0

// File: sources.f
rtl/dcache_tag_pkg.sv
rtl/tag_sram.sv
rtl/lru_matrix.sv
rtl/victim_select.sv
rtl/way_state.sv
rtl/tag_ctrl.sv
rtl/dcache_tag_top.sv
tb/dcache_tag_tb.sv

// File: tb/dcache_tag_tb.sv
`default_nettype none

module dcache_tag_tb;
  import dcache_tag_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        probe_valid_i;
  probe_req_t  probe_i;
  logic        probe_ready_o;
  logic        probe_resp_valid_o;
  probe_resp_t probe_resp_o;
  logic        alloc_valid_i;
  alloc_req_t  alloc_i;
  logic        repl_valid_o;
  repl_info_t  repl_o;
  logic        flush_valid_i;
  flush_req_t  flush_i;
  logic        invalidate_all_i;
  dirty_info_t dirty_o;
  tag_t        dirty_tag_o;

  // case table, one entry per operation line
  logic [7:0]  op_q [$];
  logic [31:0] f0_q [$];
  logic [31:0] f1_q [$];
  logic [31:0] f2_q [$];
  logic [31:0] f3_q [$];
  logic [31:0] f4_q [$];
  int          limit_cycles = 0;

  dcache_tag_top u_dcache_tag_top (
    .clk                (clk),
    .rst_n              (rst_n),
    .probe_valid_i      (probe_valid_i),
    .probe_i            (probe_i),
    .probe_ready_o      (probe_ready_o),
    .probe_resp_valid_o (probe_resp_valid_o),
    .probe_resp_o       (probe_resp_o),
    .alloc_valid_i      (alloc_valid_i),
    .alloc_i            (alloc_i),
    .repl_valid_o       (repl_valid_o),
    .repl_o             (repl_o),
    .flush_valid_i      (flush_valid_i),
    .flush_i            (flush_i),
    .invalidate_all_i   (invalidate_all_i),
    .dirty_o            (dirty_o),
    .dirty_tag_o        (dirty_tag_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      report_failure($sformatf("mismatch at time %0t: %s, got %h expected %h",
                               $time, what, got, exp));
    end
  endtask

  // ops and their hex fields, '#' lines skipped
  task automatic load_cases();
    int                fd;
    int                code;
    int                nf;
    logic [7:0]        op;
    logic [31:0]       fld [5];
    logic [8*200-1:0]  rest;
    fd = $fopen("tb/tag_cases.txt", "r");
    if (fd == 0) begin
      report_failure("could not open the case file tb/tag_cases.txt");
    end
    forever begin
      code = $fscanf(fd, " %c", op);
      if (code != 1) begin
        break;
      end
      if (op == "#") begin
        code = $fgets(rest, fd);
      end else begin
        nf = 0;
        case (op)
          "P", "A": nf = 5;
          "D":      nf = 4;
          "F":      nf = 2;
          "I":      nf = 0;
          default:  report_failure($sformatf("unknown opcode %c in the case file", op));
        endcase
        for (int i = 0; i < 5; i++) begin
          fld[i] = '0;
        end
        for (int i = 0; i < nf; i++) begin
          code = $fscanf(fd, " %h", fld[i]);
          if (code != 1) begin
            report_failure("a case line has too few fields");
          end
        end
        op_q.push_back(op);
        f0_q.push_back(fld[0]);
        f1_q.push_back(fld[1]);
        f2_q.push_back(fld[2]);
        f3_q.push_back(fld[3]);
        f4_q.push_back(fld[4]);
      end
    end
    $fclose(fd);
  endtask

  task automatic idle_cycles();
    repeat (2) begin
      @(posedge clk);
      #1;
    end
  endtask

  // hold the probe until it fires, then check the N+1 response
  task automatic send_probe(input logic [31:0] set_idx, input logic [31:0] tag_v,
                            input logic [31:0] wr, input logic [31:0] exp_hit,
                            input logic [31:0] exp_way);
    int        waited;
    way_mask_t exp_mask;
    string     ctx;
    ctx      = $sformatf("probe set %0d tag %h", set_idx, tag_v);
    exp_mask = exp_hit[0] ? (way_mask_t'(1) << exp_way) : '0;
    waited   = 0;
    probe_valid_i     = 1'b1;
    probe_i.set       = set_idx[SET_BITS-1:0];
    probe_i.tag       = tag_v[TAG_BITS-1:0];
    probe_i.is_write  = wr[0];
    @(negedge clk);
    while (!probe_ready_o) begin
      waited++;
      if (waited > 16) begin
        report_failure("probe was never accepted by the DUT");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    probe_valid_i = 1'b0;
    @(negedge clk);
    if (!probe_resp_valid_o) begin
      report_failure("probe response strobe did not arrive one cycle after the probe");
    end
    check_value(probe_resp_o.hit, exp_hit, {ctx, " hit"});
    check_value(probe_resp_o.hit_way, exp_mask, {ctx, " hit way"});
    @(posedge clk);
    #1;
    // strobe lasts a single cycle
    check_value(probe_resp_valid_o, 0, {ctx, " response strobe width"});
  endtask

  // addr of zero means the victim slot was never written
  task automatic issue_alloc(input logic [31:0] set_idx, input logic [31:0] tag_v,
                             input logic [31:0] exp_need, input logic [31:0] exp_way,
                             input logic [31:0] exp_addr);
    string ctx;
    ctx = $sformatf("allocate set %0d tag %h", set_idx, tag_v);
    alloc_valid_i = 1'b1;
    alloc_i.set   = set_idx[SET_BITS-1:0];
    alloc_i.tag   = tag_v[TAG_BITS-1:0];
    @(negedge clk);
    // allocate blocks the probe channel
    check_value(probe_ready_o, 0, {ctx, " probe ready during allocate"});
    @(posedge clk);
    #1;
    alloc_valid_i = 1'b0;
    @(negedge clk);
    if (!repl_valid_o) begin
      report_failure("replacement strobe did not arrive one cycle after the allocate");
    end
    check_value(repl_o.need_replace, exp_need, {ctx, " need_replace"});
    check_value(repl_o.victim, way_mask_t'(1) << exp_way, {ctx, " victim way"});
    if (exp_addr != 0) begin
      check_value(repl_o.addr, exp_addr, {ctx, " replacement address"});
    end
    @(posedge clk);
    #1;
    check_value(repl_valid_o, 0, {ctx, " replacement strobe width"});
  endtask

  task automatic pulse_flush(input logic [31:0] set_idx, input logic [31:0] way);
    flush_valid_i = 1'b1;
    flush_i.set   = set_idx[SET_BITS-1:0];
    flush_i.way   = way[WAY_BITS-1:0];
    @(posedge clk);
    #1;
    flush_valid_i = 1'b0;
  endtask

  task automatic pulse_invalidate();
    invalidate_all_i = 1'b1;
    @(posedge clk);
    #1;
    invalidate_all_i = 1'b0;
  endtask

  // set, way and tag only mean something with has_dirty high
  task automatic expect_dirty(input logic [31:0] exp_has, input logic [31:0] set_idx,
                              input logic [31:0] way, input logic [31:0] tag_v);
    @(negedge clk);
    check_value(dirty_o.has_dirty, exp_has, "dirty scan has_dirty");
    if (exp_has[0]) begin
      check_value(dirty_o.set, set_idx, "dirty scan set");
      check_value(dirty_o.way, way, "dirty scan way");
      check_value(dirty_tag_o, tag_v, "dirty scan tag");
    end
    @(posedge clk);
    #1;
  endtask

  // watchdog, ten cycles per case plus reset and some slack
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    report_failure("the simulation timed out before all cases finished");
  end

  initial begin
    rst_n            = 1'b0;
    probe_valid_i    = 1'b0;
    probe_i          = '0;
    alloc_valid_i    = 1'b0;
    alloc_i          = '0;
    flush_valid_i    = 1'b0;
    flush_i          = '0;
    invalidate_all_i = 1'b0;
    load_cases();
    limit_cycles = (op_q.size() + 1) * 10 + 8;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    idle_cycles();
    foreach (op_q[i]) begin
      case (op_q[i])
        "P":     send_probe(f0_q[i], f1_q[i], f2_q[i], f3_q[i], f4_q[i]);
        "A":     issue_alloc(f0_q[i], f1_q[i], f2_q[i], f3_q[i], f4_q[i]);
        "F":     pulse_flush(f0_q[i], f1_q[i]);
        "I":     pulse_invalidate();
        default: expect_dirty(f0_q[i], f1_q[i], f2_q[i], f3_q[i]);
      endcase
      idle_cycles();
    end
    if (op_q.size() > 0) begin
      $display("No errors");
      $finish;
    end else begin
      report_failure("the case file held no operations");
    end
  end

endmodule

`default_nettype wire

// File: rtl/dcache_tag_top.sv
`default_nettype none

module dcache_tag_top (
  input  wire                              clk,
  input  wire                              rst_n,
  // probe channel
  input  wire                              probe_valid_i,
  input  wire dcache_tag_pkg::probe_req_t  probe_i,
  output logic                             probe_ready_o,
  output logic                             probe_resp_valid_o,
  output dcache_tag_pkg::probe_resp_t      probe_resp_o,
  // allocate channel
  input  wire                              alloc_valid_i,
  input  wire dcache_tag_pkg::alloc_req_t  alloc_i,
  output logic                             repl_valid_o,
  output dcache_tag_pkg::repl_info_t       repl_o,
  // flush and invalidate
  input  wire                              flush_valid_i,
  input  wire dcache_tag_pkg::flush_req_t  flush_i,
  input  wire                              invalidate_all_i,
  output dcache_tag_pkg::dirty_info_t      dirty_o,
  output dcache_tag_pkg::tag_t             dirty_tag_o
);
  import dcache_tag_pkg::*;

  // tag array ports
  logic      rd_valid;
  set_idx_t  rd_set;
  set_tags_t rd_tags;
  logic      wr_valid;
  set_idx_t  wr_set;
  way_mask_t wr_way;
  tag_t      wr_tag;
  // stage-1 state exchange
  set_idx_t  st1_set;
  way_mask_t set_valid;
  way_mask_t set_dirty;
  way_mask_t victim;
  logic      hit_touch;
  logic      alloc_touch;
  logic      is_write;
  way_idx_t  touch_way;

  tag_ctrl u_tag_ctrl (
    .clk                (clk),
    .rst_n              (rst_n),
    .probe_valid_i      (probe_valid_i),
    .probe_i            (probe_i),
    .probe_ready_o      (probe_ready_o),
    .alloc_valid_i      (alloc_valid_i),
    .alloc_i            (alloc_i),
    .rd_valid_o         (rd_valid),
    .rd_set_o           (rd_set),
    .rd_tags_i          (rd_tags),
    .wr_valid_o         (wr_valid),
    .wr_set_o           (wr_set),
    .wr_way_o           (wr_way),
    .wr_tag_o           (wr_tag),
    .st1_set_o          (st1_set),
    .set_valid_i        (set_valid),
    .set_dirty_i        (set_dirty),
    .victim_i           (victim),
    .dirty_i            (dirty_o),
    .probe_resp_valid_o (probe_resp_valid_o),
    .probe_resp_o       (probe_resp_o),
    .repl_valid_o       (repl_valid_o),
    .repl_o             (repl_o),
    .hit_touch_o        (hit_touch),
    .alloc_touch_o      (alloc_touch),
    .is_write_o         (is_write),
    .touch_way_o        (touch_way),
    .dirty_tag_o        (dirty_tag_o)
  );

  tag_sram u_tag_sram (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_valid_i (rd_valid),
    .rd_set_i   (rd_set),
    .rd_tags_o  (rd_tags),
    .wr_valid_i (wr_valid),
    .wr_set_i   (wr_set),
    .wr_way_i   (wr_way),
    .wr_tag_i   (wr_tag)
  );

  way_state u_way_state (
    .clk              (clk),
    .rst_n            (rst_n),
    .st1_set_i        (st1_set),
    .hit_touch_i      (hit_touch),
    .is_write_i       (is_write),
    .touch_way_i      (touch_way),
    .alloc_touch_i    (alloc_touch),
    .flush_valid_i    (flush_valid_i),
    .flush_i          (flush_i),
    .invalidate_all_i (invalidate_all_i),
    .set_valid_o      (set_valid),
    .set_dirty_o      (set_dirty),
    .dirty_o          (dirty_o)
  );

  victim_select u_victim_select (
    .clk           (clk),
    .rst_n         (rst_n),
    .st1_set_i     (st1_set),
    .set_valid_i   (set_valid),
    .hit_touch_i   (hit_touch),
    .alloc_touch_i (alloc_touch),
    .touch_way_i   (touch_way),
    .victim_o      (victim)
  );

endmodule

`default_nettype wire

// File: rtl/tag_ctrl.sv
`default_nettype none

module tag_ctrl (
  input  wire                              clk,
  input  wire                              rst_n,
  // requests
  input  wire                              probe_valid_i,
  input  wire dcache_tag_pkg::probe_req_t  probe_i,
  output logic                             probe_ready_o,
  input  wire                              alloc_valid_i,
  input  wire dcache_tag_pkg::alloc_req_t  alloc_i,
  // tag array ports
  output logic                             rd_valid_o,
  output dcache_tag_pkg::set_idx_t         rd_set_o,
  input  wire dcache_tag_pkg::set_tags_t   rd_tags_i,
  output logic                             wr_valid_o,
  output dcache_tag_pkg::set_idx_t         wr_set_o,
  output dcache_tag_pkg::way_mask_t        wr_way_o,
  output dcache_tag_pkg::tag_t             wr_tag_o,
  // stage-1 set and its state
  output dcache_tag_pkg::set_idx_t         st1_set_o,
  input  wire dcache_tag_pkg::way_mask_t   set_valid_i,
  input  wire dcache_tag_pkg::way_mask_t   set_dirty_i,
  input  wire dcache_tag_pkg::way_mask_t   victim_i,
  input  wire dcache_tag_pkg::dirty_info_t dirty_i,
  // responses
  output logic                             probe_resp_valid_o,
  output dcache_tag_pkg::probe_resp_t      probe_resp_o,
  output logic                             repl_valid_o,
  output dcache_tag_pkg::repl_info_t       repl_o,
  // state updates
  output logic                             hit_touch_o,
  output logic                             alloc_touch_o,
  output logic                             is_write_o,
  output dcache_tag_pkg::way_idx_t         touch_way_o,
  output dcache_tag_pkg::tag_t             dirty_tag_o
);
  import dcache_tag_pkg::*;

  logic      probe_fire;
  logic      scan_rd;
  logic      st1_probe_q;
  logic      st1_alloc_q;
  logic      st1_scan_q;
  logic      st1_write_q;
  set_idx_t  st1_set_q;
  tag_t      st1_tag_q;
  way_idx_t  scan_way_q;
  tag_t      scan_tag_q;
  way_mask_t hit_way;
  way_idx_t  hit_idx;
  way_idx_t  vic_idx;
  tag_t      vic_tag;
  tag_t      scan_tag;

  // allocate owns the port, probe stalls behind it
  assign probe_ready_o = !alloc_valid_i;
  assign probe_fire    = probe_valid_i && probe_ready_o;
  // dirty scan only fills idle cycles
  assign scan_rd       = !alloc_valid_i && !probe_fire && dirty_i.has_dirty;

  assign rd_valid_o = alloc_valid_i || probe_fire || scan_rd;
  assign rd_set_o   = alloc_valid_i ? alloc_i.set :
                      probe_fire    ? probe_i.set : dirty_i.set;

  // stage-1 ownership and steering state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      st1_alloc_q <= 1'b0;
      st1_probe_q <= 1'b0;
      st1_scan_q  <= 1'b0;
      st1_write_q <= 1'b0;
      st1_set_q   <= '0;
      scan_way_q  <= '0;
    end else begin
      st1_alloc_q <= alloc_valid_i;
      st1_probe_q <= probe_fire;
      st1_scan_q  <= scan_rd;
      if (alloc_valid_i) begin
        st1_set_q   <= alloc_i.set;
        st1_write_q <= 1'b0;
      end else if (probe_fire) begin
        st1_set_q   <= probe_i.set;
        st1_write_q <= probe_i.is_write;
      end
      if (scan_rd) begin
        scan_way_q <= dirty_i.way;
      end
    end
  end

  // request tag and last scanned tag
  always_ff @(posedge clk) begin
    if (alloc_valid_i) begin
      st1_tag_q <= alloc_i.tag;
    end else if (probe_fire) begin
      st1_tag_q <= probe_i.tag;
    end
    if (st1_scan_q) begin
      scan_tag_q <= scan_tag;
    end
  end

  // tag compare against valid ways only
  always_comb begin
    hit_way = '0;
    hit_idx = '0;
    for (int w = 0; w < NUM_WAY; w++) begin
      if (set_valid_i[w] && rd_tags_i[w*TAG_BITS +: TAG_BITS] == st1_tag_q) begin
        hit_way[w] = 1'b1;
        hit_idx    = way_idx_t'(w);
      end
    end
  end

  // victim mask to way number
  always_comb begin
    vic_idx = '0;
    for (int w = 0; w < NUM_WAY; w++) begin
      if (victim_i[w]) begin
        vic_idx = way_idx_t'(w);
      end
    end
  end

  assign vic_tag  = rd_tags_i[vic_idx*TAG_BITS +: TAG_BITS];
  assign scan_tag = rd_tags_i[scan_way_q*TAG_BITS +: TAG_BITS];

  assign probe_resp_valid_o = st1_probe_q;
  assign probe_resp_o       = '{hit: |hit_way, hit_way: hit_way};

  // old tag, set, zero offset
  assign repl_valid_o = st1_alloc_q;
  assign repl_o       = '{need_replace: |(victim_i & set_valid_i & set_dirty_i),
                          victim:       victim_i,
                          addr:         {vic_tag, st1_set_q, {OFFSET_BITS{1'b0}}}};

  // new tag goes in during stage 1 of the allocate
  assign wr_valid_o = st1_alloc_q;
  assign wr_set_o   = st1_set_q;
  assign wr_way_o   = victim_i;
  assign wr_tag_o   = st1_tag_q;

  assign st1_set_o     = st1_set_q;
  assign hit_touch_o   = st1_probe_q && (|hit_way);
  assign alloc_touch_o = st1_alloc_q;
  assign is_write_o    = st1_write_q;
  assign touch_way_o   = st1_alloc_q ? vic_idx : hit_idx;
  // fresh tag right after a scan read, held otherwise
  assign dirty_tag_o   = st1_scan_q ? scan_tag : scan_tag_q;

endmodule

`default_nettype wire

// File: rtl/way_state.sv
`default_nettype none

module way_state (
  input  wire                              clk,
  input  wire                              rst_n,
  // stage-1 request view
  input  wire dcache_tag_pkg::set_idx_t    st1_set_i,
  input  wire                              hit_touch_i,
  input  wire                              is_write_i,
  input  wire dcache_tag_pkg::way_idx_t    touch_way_i,
  input  wire                              alloc_touch_i,
  // maintenance strobes
  input  wire                              flush_valid_i,
  input  wire dcache_tag_pkg::flush_req_t  flush_i,
  input  wire                              invalidate_all_i,
  // bits of the stage-1 set
  output dcache_tag_pkg::way_mask_t        set_valid_o,
  output dcache_tag_pkg::way_mask_t        set_dirty_o,
  // lowest valid dirty line
  output dcache_tag_pkg::dirty_info_t      dirty_o
);
  import dcache_tag_pkg::*;

  way_mask_t valid_q [NUM_SET];
  way_mask_t dirty_q [NUM_SET];
  way_mask_t live    [NUM_SET];
  logic      has_dirty;
  set_idx_t  scan_set;
  way_idx_t  scan_way;

  // valid bits
  // allocate wins over a same-cycle invalidate
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_SET; s++) begin
        valid_q[s] <= '0;
      end
    end else begin
      if (invalidate_all_i) begin
        for (int s = 0; s < NUM_SET; s++) begin
          valid_q[s] <= '0;
        end
      end
      if (alloc_touch_i) begin
        valid_q[st1_set_i][touch_way_i] <= 1'b1;
      end
    end
  end

  // dirty bits, later assignment has priority
  // write hit over flush over replacement
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_SET; s++) begin
        dirty_q[s] <= '0;
      end
    end else begin
      if (alloc_touch_i) begin
        dirty_q[st1_set_i][touch_way_i] <= 1'b0;
      end
      if (flush_valid_i) begin
        dirty_q[flush_i.set][flush_i.way] <= 1'b0;
      end
      if (hit_touch_i && is_write_i) begin
        dirty_q[st1_set_i][touch_way_i] <= 1'b1;
      end
    end
  end

  assign set_valid_o = valid_q[st1_set_i];
  assign set_dirty_o = dirty_q[st1_set_i];

  // stale dirty bits hide behind valid
  always_comb begin
    for (int s = 0; s < NUM_SET; s++) begin
      live[s] = valid_q[s] & dirty_q[s];
    end
  end

  // lowest set holding a live dirty line
  always_comb begin
    has_dirty = 1'b0;
    scan_set  = '0;
    for (int s = NUM_SET-1; s >= 0; s--) begin
      if (|live[s]) begin
        has_dirty = 1'b1;
        scan_set  = set_idx_t'(s);
      end
    end
  end

  // lowest dirty way in that set
  always_comb begin
    scan_way = '0;
    for (int w = NUM_WAY-1; w >= 0; w--) begin
      if (live[scan_set][w]) begin
        scan_way = way_idx_t'(w);
      end
    end
  end

  assign dirty_o = '{has_dirty: has_dirty, set: scan_set, way: scan_way};

endmodule

`default_nettype wire

// File: rtl/victim_select.sv
`default_nettype none

module victim_select (
  input  wire                            clk,
  input  wire                            rst_n,
  // set currently in stage 1
  input  wire dcache_tag_pkg::set_idx_t  st1_set_i,
  input  wire dcache_tag_pkg::way_mask_t set_valid_i,
  // recency updates from stage 1
  input  wire                            hit_touch_i,
  input  wire                            alloc_touch_i,
  input  wire dcache_tag_pkg::way_idx_t  touch_way_i,
  // one-hot victim for an allocate
  output dcache_tag_pkg::way_mask_t      victim_o
);
  import dcache_tag_pkg::*;

  logic     touch_any;
  way_idx_t lru_way [NUM_SET];

  // hits and allocates both refresh recency
  assign touch_any = hit_touch_i || alloc_touch_i;

  for (genvar s = 0; s < NUM_SET; s++) begin : g_set
    // only the stage-1 set sees the touch
    lru_matrix u_lru_matrix (
      .clk         (clk),
      .rst_n       (rst_n),
      .touch_i     (touch_any && (st1_set_i == set_idx_t'(s))),
      .touch_way_i (touch_way_i),
      .lru_way_o   (lru_way[s])
    );
  end

  always_comb begin
    victim_o = '0;
    if (&set_valid_i) begin
      // full set, evict the oldest way
      victim_o[lru_way[st1_set_i]] = 1'b1;
    end else begin
      // free slot, lowest invalid way wins
      for (int w = NUM_WAY-1; w >= 0; w--) begin
        if (!set_valid_i[w]) begin
          victim_o    = '0;
          victim_o[w] = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/lru_matrix.sv
`default_nettype none

module lru_matrix (
  input  wire                           clk,
  input  wire                           rst_n,
  // touched way becomes most recent
  input  wire                           touch_i,
  input  wire dcache_tag_pkg::way_idx_t touch_way_i,
  output dcache_tag_pkg::way_idx_t      lru_way_o
);
  import dcache_tag_pkg::*;

  // age_q[r][c] set means way r is newer than way c
  way_mask_t age_q [NUM_WAY];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // way 0 oldest, way 3 newest
      for (int r = 0; r < NUM_WAY; r++) begin
        for (int c = 0; c < NUM_WAY; c++) begin
          age_q[r][c] <= (c < r);
        end
      end
    end else if (touch_i) begin
      for (int r = 0; r < NUM_WAY; r++) begin
        for (int c = 0; c < NUM_WAY; c++) begin
          if (r == int'(touch_way_i) && c != r) begin
            // row of touched way goes to ones
            age_q[r][c] <= 1'b1;
          end else if (c == int'(touch_way_i)) begin
            // nobody is newer than the touched way
            age_q[r][c] <= 1'b0;
          end
        end
      end
    end
  end

  // oldest way has an empty row
  always_comb begin
    lru_way_o = '0;
    for (int r = 0; r < NUM_WAY; r++) begin
      if (age_q[r] == '0) begin
        lru_way_o = way_idx_t'(r);
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/tag_sram.sv
`default_nettype none

module tag_sram (
  input  wire                           clk,
  input  wire                           rst_n,
  // read port, whole set per access
  input  wire                           rd_valid_i,
  input  wire dcache_tag_pkg::set_idx_t rd_set_i,
  output dcache_tag_pkg::set_tags_t     rd_tags_o,
  // write port, one way per mask bit
  input  wire                           wr_valid_i,
  input  wire dcache_tag_pkg::set_idx_t wr_set_i,
  input  wire dcache_tag_pkg::way_mask_t wr_way_i,
  input  wire dcache_tag_pkg::tag_t     wr_tag_i
);
  import dcache_tag_pkg::*;

  // tag storage, one entry per set
  set_tags_t mem_q [NUM_SET];

  // masked write, untouched ways keep their tags
  always_ff @(posedge clk) begin
    if (wr_valid_i) begin
      for (int w = 0; w < NUM_WAY; w++) begin
        if (wr_way_i[w]) begin
          mem_q[wr_set_i][w*TAG_BITS +: TAG_BITS] <= wr_tag_i;
        end
      end
    end
  end

  // registered read
  // same-cycle write is not visible, reader gets the old tag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_tags_o <= '0;
    end else if (rd_valid_i) begin
      rd_tags_o <= mem_q[rd_set_i];
    end
  end

endmodule

`default_nettype wire

// File: rtl/dcache_tag_pkg.sv
`default_nettype none

package dcache_tag_pkg;

  // cache geometry
  localparam int NUM_SET     = 32;
  localparam int NUM_WAY     = 4;
  localparam int TAG_BITS    = 24;
  localparam int SET_BITS    = 5;
  localparam int WAY_BITS    = 2;
  // block plus word offset inside the address
  localparam int OFFSET_BITS = 3;
  localparam int ADDR_BITS   = 32;

  typedef logic [SET_BITS-1:0]         set_idx_t;
  typedef logic [WAY_BITS-1:0]         way_idx_t;
  typedef logic [NUM_WAY-1:0]          way_mask_t;
  typedef logic [TAG_BITS-1:0]         tag_t;
  typedef logic [ADDR_BITS-1:0]        addr_t;
  // way 0 sits in the low bits
  typedef logic [NUM_WAY*TAG_BITS-1:0] set_tags_t;

  typedef struct packed {
    set_idx_t set;
    tag_t     tag;
    logic     is_write;
  } probe_req_t;

  typedef struct packed {
    set_idx_t set;
    tag_t     tag;
  } alloc_req_t;

  typedef struct packed {
    logic      hit;
    way_mask_t hit_way;
  } probe_resp_t;

  typedef struct packed {
    logic      need_replace;
    way_mask_t victim;
    addr_t     addr;
  } repl_info_t;

  typedef struct packed {
    logic     has_dirty;
    set_idx_t set;
    way_idx_t way;
  } dirty_info_t;

  typedef struct packed {
    set_idx_t set;
    way_idx_t way;
  } flush_req_t;

endpackage

`default_nettype wire
